// File: hw/imx_ctrl_consts.svh
`ifndef IMX_CTRL_CONSTS_SVH
`define IMX_CTRL_CONSTS_SVH

// Bus widths
`define IMX_ADDR_WIDTH              8
`define IMX_DATA_WIDTH              32

// Number of master-mode outputs, one per camera
`define IMX_CAMERA_COUNT            3

// Reset values of the timing registers
`define IMX_DEFAULT_CLEAR_LEN       100
`define IMX_DEFAULT_TRIGGER_LEN     100
`define IMX_DEFAULT_TRIGGER_PERIOD  370000

// Control register bit positions
`define IMX_CTRL_BIT_CLEAR          0
`define IMX_CTRL_BIT_TRIGGER_EN     2
`define IMX_CTRL_BIT_MASTER_MODE0   8

// Version word, values sized to their fields
`define IMX_VERSION_MAJOR           4'd1
`define IMX_VERSION_MINOR           8'd0
`define IMX_VERSION_REVISION        4'd0
`define IMX_VERSION_MAJOR_RANGE     31:28
`define IMX_VERSION_MINOR_RANGE     27:20
`define IMX_VERSION_REVISION_RANGE  19:16

`endif

// File: hw/imx_ctrl_pkg.sv
package imx_ctrl_pkg;

  // Word address map of the register file
  typedef enum logic [4:0] {
    REG_CONTROL        = 5'd0,
    REG_CLEAR_WIDTH    = 5'd2,
    REG_TRIGGER_WIDTH  = 5'd3,
    REG_TRIGGER_PERIOD = 5'd4,
    REG_CAMERA_COUNT   = 5'd5,
    REG_VERSION        = 5'd7
  } imx_reg_addr_e;

  typedef enum logic [1:0] {
    AXI_RESP_OKAY   = 2'd0,
    AXI_RESP_SLVERR = 2'd2
  } axi_resp_e;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WR_STB,
    ST_WR_RESP,
    ST_RD_STB,
    ST_RD_RESP
  } axi_slave_state_e;

endpackage

// File: hw/axi_lite_reg_slave.sv
`timescale 1ns/1ps
`include "imx_ctrl_consts.svh"

module axi_lite_reg_slave (
  input  logic                          clk,
  input  logic                          w_axi_rst,

  // Write address and data
  input  logic                          i_awvalid,
  input  logic [`IMX_ADDR_WIDTH-1:0]    i_awaddr,
  output logic                          o_awready,
  input  logic                          i_wvalid,
  input  logic [`IMX_DATA_WIDTH-1:0]    i_wdata,
  output logic                          o_wready,

  // Write response
  output logic                          o_bvalid,
  input  logic                          i_bready,
  output imx_ctrl_pkg::axi_resp_e       o_bresp,

  // Read address and data
  input  logic                          i_arvalid,
  input  logic [`IMX_ADDR_WIDTH-1:0]    i_araddr,
  output logic                          o_arready,
  output logic                          o_rvalid,
  input  logic                          i_rready,
  output imx_ctrl_pkg::axi_resp_e       o_rresp,
  output logic [`IMX_DATA_WIDTH-1:0]    o_rdata,

  // Strobe bus to the register file
  output imx_ctrl_pkg::imx_reg_addr_e   o_reg_addr,
  output logic                          o_reg_wr_stb,
  output logic                          o_reg_rd_stb,
  output logic [`IMX_DATA_WIDTH-1:0]    o_reg_wdata,
  input  logic                          i_reg_ack,
  input  logic                          i_reg_err,
  input  logic [`IMX_DATA_WIDTH-1:0]    i_reg_rdata
);
  import imx_ctrl_pkg::*;

  axi_slave_state_e r_state;
  logic             w_wr_accept;
  logic             w_rd_accept;
  logic             w_wr_ack;
  logic             w_rd_ack;

  // A write needs address and data together, and wins over a read
  assign w_wr_accept  = (r_state == ST_IDLE) && i_awvalid && i_wvalid;
  assign w_rd_accept  = (r_state == ST_IDLE) && i_arvalid && !(i_awvalid && i_wvalid);

  assign o_awready    = w_wr_accept;
  assign o_wready     = w_wr_accept;
  assign o_arready    = w_rd_accept;

  assign o_reg_wr_stb = (r_state == ST_WR_STB);
  assign o_reg_rd_stb = (r_state == ST_RD_STB);

  // Acknowledge from the register file, only seen while waiting for it
  assign w_wr_ack     = (r_state == ST_WR_RESP) && i_reg_ack;
  assign w_rd_ack     = (r_state == ST_RD_RESP) && i_reg_ack;

  always_ff @(posedge clk) begin
    if (w_axi_rst) begin
      r_state  <= ST_IDLE;
      o_bvalid <= 1'b0;
      o_rvalid <= 1'b0;
    end else begin
      case (r_state)
        ST_IDLE: begin
          if (w_wr_accept) begin
            r_state <= ST_WR_STB;
          end else if (w_rd_accept) begin
            r_state <= ST_RD_STB;
          end
        end
        ST_WR_STB: r_state <= ST_WR_RESP;
        ST_WR_RESP: begin
          if (w_wr_ack) begin
            o_bvalid <= 1'b1;
          end else if (o_bvalid && i_bready) begin
            o_bvalid <= 1'b0;
            r_state  <= ST_IDLE;
          end
        end
        ST_RD_STB: r_state <= ST_RD_RESP;
        ST_RD_RESP: begin
          if (w_rd_ack) begin
            o_rvalid <= 1'b1;
          end else if (o_rvalid && i_rready) begin
            o_rvalid <= 1'b0;
            r_state  <= ST_IDLE;
          end
        end
        default: r_state <= ST_IDLE;
      endcase
    end
  end

  // Word address comes from byte address bits 6:2
  always_ff @(posedge clk) begin
    if (w_wr_accept) begin
      o_reg_addr  <= imx_reg_addr_e'(i_awaddr[6:2]);
      o_reg_wdata <= i_wdata;
    end else if (w_rd_accept) begin
      o_reg_addr  <= imx_reg_addr_e'(i_araddr[6:2]);
    end
    if (w_wr_ack) begin
      o_bresp <= i_reg_err ? AXI_RESP_SLVERR : AXI_RESP_OKAY;
    end
    if (w_rd_ack) begin
      o_rresp <= i_reg_err ? AXI_RESP_SLVERR : AXI_RESP_OKAY;
      o_rdata <= i_reg_rdata;
    end
  end

  // Response held steady under back-pressure
  a_bvalid_hold: assert property (@(posedge clk) disable iff (w_axi_rst)
    o_bvalid && !i_bready |=> o_bvalid && $stable(o_bresp));

  a_one_strobe: assert property (@(posedge clk) disable iff (w_axi_rst)
    !(o_reg_wr_stb && o_reg_rd_stb));

endmodule

// File: hw/imx_ctrl_regs.sv
`timescale 1ns/1ps
`include "imx_ctrl_consts.svh"

module imx_ctrl_regs (
  input  logic                          clk,
  input  logic                          w_axi_rst,
  input  imx_ctrl_pkg::imx_reg_addr_e   i_reg_addr,
  input  logic                          i_reg_wr_stb,
  input  logic                          i_reg_rd_stb,
  input  logic [`IMX_DATA_WIDTH-1:0]    i_reg_wdata,
  input  logic                          i_clear_active,
  output logic                          o_reg_ack,
  output logic                          o_reg_err,
  output logic [`IMX_DATA_WIDTH-1:0]    o_reg_rdata,
  output logic [`IMX_DATA_WIDTH-1:0]    o_clear_width,
  output logic [`IMX_DATA_WIDTH-1:0]    o_trigger_width,
  output logic [`IMX_DATA_WIDTH-1:0]    o_trigger_period,
  output logic                          o_trigger_en,
  output logic                          o_width_load,
  output logic                          o_period_load,
  output logic                          o_clear_start,
  output logic [`IMX_CAMERA_COUNT-1:0]  o_cam_master_mode
);
  import imx_ctrl_pkg::*;

  logic                         w_mapped;
  logic                         w_stb;
  logic [`IMX_DATA_WIDTH-1:0]   w_rdata;

  assign w_stb = i_reg_wr_stb || i_reg_rd_stb;

  // Address decode and read mux
  always_comb begin
    w_mapped = 1'b1;
    w_rdata  = '0;
    case (i_reg_addr)
      REG_CONTROL: begin
        w_rdata[`IMX_CTRL_BIT_CLEAR]      = i_clear_active;
        w_rdata[`IMX_CTRL_BIT_TRIGGER_EN] = o_trigger_en;
        w_rdata[`IMX_CTRL_BIT_MASTER_MODE0 +: `IMX_CAMERA_COUNT] = o_cam_master_mode;
      end
      REG_CLEAR_WIDTH:    w_rdata = o_clear_width;
      REG_TRIGGER_WIDTH:  w_rdata = o_trigger_width;
      REG_TRIGGER_PERIOD: w_rdata = o_trigger_period;
      REG_CAMERA_COUNT:   w_rdata = `IMX_CAMERA_COUNT;
      REG_VERSION: begin
        w_rdata[`IMX_VERSION_MAJOR_RANGE]    = `IMX_VERSION_MAJOR;
        w_rdata[`IMX_VERSION_MINOR_RANGE]    = `IMX_VERSION_MINOR;
        w_rdata[`IMX_VERSION_REVISION_RANGE] = `IMX_VERSION_REVISION;
      end
      default: w_mapped = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (w_axi_rst) begin
      o_reg_ack         <= 1'b0;
      o_reg_err         <= 1'b0;
      o_clear_width     <= `IMX_DEFAULT_CLEAR_LEN;
      o_trigger_width   <= `IMX_DEFAULT_TRIGGER_LEN;
      o_trigger_period  <= `IMX_DEFAULT_TRIGGER_PERIOD;
      o_trigger_en      <= 1'b0;
      o_width_load      <= 1'b0;
      o_period_load     <= 1'b0;
      o_clear_start     <= 1'b0;
      o_cam_master_mode <= '0;
    end else begin
      o_reg_ack     <= w_stb;
      o_reg_err     <= w_stb && !w_mapped;
      o_width_load  <= 1'b0;
      o_period_load <= 1'b0;
      o_clear_start <= 1'b0;
      if (i_reg_wr_stb) begin
        case (i_reg_addr)
          REG_CONTROL: begin
            o_trigger_en      <= i_reg_wdata[`IMX_CTRL_BIT_TRIGGER_EN];
            o_cam_master_mode <= i_reg_wdata[`IMX_CTRL_BIT_MASTER_MODE0 +: `IMX_CAMERA_COUNT];
            o_clear_start     <= i_reg_wdata[`IMX_CTRL_BIT_CLEAR];
          end
          REG_CLEAR_WIDTH: begin
            o_clear_width <= i_reg_wdata;
            o_width_load  <= 1'b1;
          end
          REG_TRIGGER_WIDTH: begin
            o_trigger_width <= i_reg_wdata;
            o_width_load    <= 1'b1;
          end
          REG_TRIGGER_PERIOD: begin
            o_trigger_period <= i_reg_wdata;
            o_period_load    <= 1'b1;
          end
          // Camera count and version ignore writes
          default: begin
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_reg_rd_stb) begin
      o_reg_rdata <= w_rdata;
    end
  end

  a_ack_after_stb: assert property (@(posedge clk) disable iff (w_axi_rst)
    (i_reg_wr_stb || i_reg_rd_stb) |=> o_reg_ack);

endmodule

// File: hw/imx_exposure_timing.sv
`timescale 1ns/1ps
`include "imx_ctrl_consts.svh"

module imx_exposure_timing (
  input  logic                        clk,
  input  logic                        w_axi_rst,
  input  logic [`IMX_DATA_WIDTH-1:0]  i_clear_width,
  input  logic [`IMX_DATA_WIDTH-1:0]  i_trigger_width,
  input  logic [`IMX_DATA_WIDTH-1:0]  i_trigger_period,
  input  logic                        i_trigger_en,
  input  logic                        i_width_load,
  input  logic                        i_period_load,
  input  logic                        i_clear_start,
  output logic                        o_imx_trigger,
  output logic                        o_cam_xclear_n,
  output logic                        o_clear_active
);

  logic [`IMX_DATA_WIDTH-1:0] r_clear_count;
  logic [`IMX_DATA_WIDTH-1:0] r_pulse_count;
  logic [`IMX_DATA_WIDTH-1:0] r_period_count;
  logic                       w_wrap;

  // Outputs are active while their count is below the width
  assign o_clear_active = (r_clear_count < i_clear_width);
  assign o_cam_xclear_n = !o_clear_active;
  assign o_imx_trigger  = (r_pulse_count < i_trigger_width);

  // End of period, restarts both trigger counters
  assign w_wrap = i_trigger_en && !i_period_load && (r_period_count >= i_trigger_period);

  // One-shot clear pulse
  always_ff @(posedge clk) begin
    if (w_axi_rst) begin
      r_clear_count <= `IMX_DEFAULT_CLEAR_LEN;
    end else if (i_clear_start) begin
      r_clear_count <= '0;
    end else if (i_width_load) begin
      r_clear_count <= i_clear_width;
    end else if (o_clear_active) begin
      r_clear_count <= r_clear_count + 1'b1;
    end
  end

  // Periodic trigger, counters park at their limits while disabled
  always_ff @(posedge clk) begin
    if (w_axi_rst) begin
      r_pulse_count  <= `IMX_DEFAULT_TRIGGER_LEN;
      r_period_count <= `IMX_DEFAULT_TRIGGER_PERIOD;
    end else begin
      if (!i_trigger_en || i_width_load) begin
        r_pulse_count <= i_trigger_width;
      end else if (w_wrap) begin
        r_pulse_count <= '0;
      end else if (o_imx_trigger) begin
        r_pulse_count <= r_pulse_count + 1'b1;
      end

      if (!i_trigger_en || i_period_load) begin
        r_period_count <= i_trigger_period;
      end else if (w_wrap) begin
        r_period_count <= '0;
      end else begin
        r_period_count <= r_period_count + 1'b1;
      end
    end
  end

  // A new period value arrives together with its load pulse
  a_period_bound: assert property (@(posedge clk) disable iff (w_axi_rst)
    !i_period_load |-> r_period_count <= i_trigger_period);

endmodule

// File: hw/axi_imx_control.sv
`timescale 1ns/1ps
`include "imx_ctrl_consts.svh"

module axi_imx_control (
  input  logic                          clk,
  input  logic                          w_axi_rst,
  input  logic                          i_awvalid,
  input  logic [`IMX_ADDR_WIDTH-1:0]    i_awaddr,
  output logic                          o_awready,
  input  logic                          i_wvalid,
  input  logic [`IMX_DATA_WIDTH-1:0]    i_wdata,
  output logic                          o_wready,
  output logic                          o_bvalid,
  input  logic                          i_bready,
  output logic [1:0]                    o_bresp,
  input  logic                          i_arvalid,
  input  logic [`IMX_ADDR_WIDTH-1:0]    i_araddr,
  output logic                          o_arready,
  output logic                          o_rvalid,
  input  logic                          i_rready,
  output logic [1:0]                    o_rresp,
  output logic [`IMX_DATA_WIDTH-1:0]    o_rdata,
  output logic                          o_imx_trigger,
  output logic                          o_cam_xclear_n,
  output logic [`IMX_CAMERA_COUNT-1:0]  o_cam_master_mode
);
  import imx_ctrl_pkg::*;

  // Strobe bus
  imx_reg_addr_e                w_reg_addr;
  logic                         w_reg_wr_stb;
  logic                         w_reg_rd_stb;
  logic [`IMX_DATA_WIDTH-1:0]   w_reg_wdata;
  logic                         w_reg_ack;
  logic                         w_reg_err;
  logic [`IMX_DATA_WIDTH-1:0]   w_reg_rdata;

  // Settings and pulses to the timing block
  logic [`IMX_DATA_WIDTH-1:0]   w_clear_width;
  logic [`IMX_DATA_WIDTH-1:0]   w_trigger_width;
  logic [`IMX_DATA_WIDTH-1:0]   w_trigger_period;
  logic                         w_trigger_en;
  logic                         w_width_load;
  logic                         w_period_load;
  logic                         w_clear_start;
  logic                         w_clear_active;

  // AXI ports connect by name
  axi_lite_reg_slave reg_slave (
    .*,
    .o_reg_addr   (w_reg_addr),
    .o_reg_wr_stb (w_reg_wr_stb),
    .o_reg_rd_stb (w_reg_rd_stb),
    .o_reg_wdata  (w_reg_wdata),
    .i_reg_ack    (w_reg_ack),
    .i_reg_err    (w_reg_err),
    .i_reg_rdata  (w_reg_rdata)
  );

  imx_ctrl_regs ctrl_regs (
    .clk               (clk),
    .w_axi_rst         (w_axi_rst),
    .i_reg_addr        (w_reg_addr),
    .i_reg_wr_stb      (w_reg_wr_stb),
    .i_reg_rd_stb      (w_reg_rd_stb),
    .i_reg_wdata       (w_reg_wdata),
    .i_clear_active    (w_clear_active),
    .o_reg_ack         (w_reg_ack),
    .o_reg_err         (w_reg_err),
    .o_reg_rdata       (w_reg_rdata),
    .o_clear_width     (w_clear_width),
    .o_trigger_width   (w_trigger_width),
    .o_trigger_period  (w_trigger_period),
    .o_trigger_en      (w_trigger_en),
    .o_width_load      (w_width_load),
    .o_period_load     (w_period_load),
    .o_clear_start     (w_clear_start),
    .o_cam_master_mode (o_cam_master_mode)
  );

  imx_exposure_timing exposure_timing (
    .clk              (clk),
    .w_axi_rst        (w_axi_rst),
    .i_clear_width    (w_clear_width),
    .i_trigger_width  (w_trigger_width),
    .i_trigger_period (w_trigger_period),
    .i_trigger_en     (w_trigger_en),
    .i_width_load     (w_width_load),
    .i_period_load    (w_period_load),
    .i_clear_start    (w_clear_start),
    .o_imx_trigger    (o_imx_trigger),
    .o_cam_xclear_n   (o_cam_xclear_n),
    .o_clear_active   (w_clear_active)
  );

endmodule

// File: verification/imx_ctrl_checker.sv
`timescale 1ns/1ps
`include "imx_ctrl_consts.svh"

module imx_ctrl_checker (
  input  logic                          clk,
  input  logic                          w_axi_rst,
  input  logic                          i_bvalid,
  input  logic                          i_bready,
  input  logic [1:0]                    i_bresp,
  input  logic                          i_rvalid,
  input  logic                          i_rready,
  input  logic [1:0]                    i_rresp,
  input  logic [`IMX_DATA_WIDTH-1:0]    i_rdata,
  input  logic                          i_imx_trigger,
  input  logic                          i_cam_xclear_n,
  input  logic [`IMX_CAMERA_COUNT-1:0]  i_cam_master_mode,
  input  logic [1:0]                    i_exp_resp,
  input  logic [`IMX_DATA_WIDTH-1:0]    i_exp_rdata,
  input  logic                          i_port_chk,
  input  logic [`IMX_CAMERA_COUNT-1:0]  i_exp_master,
  input  logic                          i_exp_trigger,
  input  logic                          i_exp_xclear_n,
  input  logic                          i_trig_chk,
  input  logic [31:0]                   i_exp_trig_width,
  input  logic [31:0]                   i_exp_trig_period,
  input  logic                          i_no_trig_chk,
  input  logic                          i_clear_chk,
  input  logic [31:0]                   i_exp_clear_width,
  input  logic                          i_final_chk
);

  int   error_count  = 0;
  int   cycle        = 0;
  int   last_rise    = 0;
  int   high_len     = 0;
  int   low_len      = 0;
  int   trig_pulses  = 0;
  int   clear_pulses = 0;
  logic prev_trig    = 1'b0;
  logic prev_xclear_n = 1'b1;
  logic have_rise    = 1'b0;
  logic pulse_valid  = 1'b0;

  task report_mismatch(input string name, input logic [31:0] exp_val, input logic [31:0] act_val);
    error_count++;
    $display("Mismatch at %0t: %s expected %0h actual %0h", $time, name, exp_val, act_val);
  endtask

  task report_failure(input string what);
    error_count++;
    $display("Error at %0t: %s", $time, what);
  endtask

  always @(posedge clk) begin
    cycle++;
    if (!w_axi_rst) begin
      // Responses are compared on their handshake edge
      if (i_bvalid && i_bready && i_bresp != i_exp_resp)
        report_mismatch("o_bresp", 32'(i_exp_resp), 32'(i_bresp));
      if (i_rvalid && i_rready && i_rresp != i_exp_resp)
        report_mismatch("o_rresp", 32'(i_exp_resp), 32'(i_rresp));
      if (i_rvalid && i_rready && i_rdata != i_exp_rdata)
        report_mismatch("o_rdata", i_exp_rdata, i_rdata);

      if (i_port_chk) begin
        if (i_cam_master_mode != i_exp_master)
          report_mismatch("o_cam_master_mode", 32'(i_exp_master), 32'(i_cam_master_mode));
        if (i_imx_trigger != i_exp_trigger)
          report_mismatch("o_imx_trigger", 32'(i_exp_trigger), 32'(i_imx_trigger));
        if (i_cam_xclear_n != i_exp_xclear_n)
          report_mismatch("o_cam_xclear_n", 32'(i_exp_xclear_n), 32'(i_cam_xclear_n));
      end

      // Trigger period from rise to rise, width from rise to fall
      if (i_imx_trigger && !prev_trig) begin
        if (i_no_trig_chk)
          report_failure("o_imx_trigger rose while the trigger was disabled");
        if (i_trig_chk && have_rise && (cycle - last_rise) != i_exp_trig_period + 1)
          report_mismatch("o_imx_trigger period", i_exp_trig_period + 1, cycle - last_rise);
        have_rise   = i_trig_chk;
        last_rise   = cycle;
        high_len    = 1;
        pulse_valid = i_trig_chk;
      end else if (i_imx_trigger) begin
        high_len++;
      end else if (prev_trig && pulse_valid && i_trig_chk) begin
        if (high_len != i_exp_trig_width)
          report_mismatch("o_imx_trigger width", i_exp_trig_width, high_len);
        trig_pulses++;
      end
      if (!i_trig_chk) begin
        have_rise   = 1'b0;
        pulse_valid = 1'b0;
      end
      prev_trig = i_imx_trigger;

      // Clear pulse is active low
      if (!i_cam_xclear_n && prev_xclear_n) begin
        low_len = 1;
      end else if (!i_cam_xclear_n) begin
        low_len++;
      end else if (!prev_xclear_n && i_clear_chk) begin
        if (low_len != i_exp_clear_width)
          report_mismatch("o_cam_xclear_n low width", i_exp_clear_width, low_len);
        clear_pulses++;
      end
      prev_xclear_n = i_cam_xclear_n;

      if (i_final_chk) begin
        if (trig_pulses < 3)
          report_failure("fewer than three trigger pulses were measured");
        if (clear_pulses < 1)
          report_failure("no clear pulse was measured");
      end
    end
  end

endmodule

// File: verification/tb_axi_imx_control.sv
`timescale 1ns/1ps
`include "imx_ctrl_consts.svh"

module tb_axi_imx_control;

  localparam int TIMEOUT  = 200;
  localparam int MAX_CMDS = 64;

  logic                          clk;
  logic                          w_axi_rst;
  logic                          awvalid;
  logic [`IMX_ADDR_WIDTH-1:0]    awaddr;
  logic                          wvalid;
  logic [`IMX_DATA_WIDTH-1:0]    wdata;
  logic                          bready;
  logic                          arvalid;
  logic [`IMX_ADDR_WIDTH-1:0]    araddr;
  logic                          rready;
  logic                          o_awready;
  logic                          o_wready;
  logic                          o_bvalid;
  logic [1:0]                    o_bresp;
  logic                          o_arready;
  logic                          o_rvalid;
  logic [1:0]                    o_rresp;
  logic [`IMX_DATA_WIDTH-1:0]    o_rdata;
  logic                          o_imx_trigger;
  logic                          o_cam_xclear_n;
  logic [`IMX_CAMERA_COUNT-1:0]  o_cam_master_mode;

  // Expected values handed to the checker
  logic [1:0]                    exp_resp;
  logic [`IMX_DATA_WIDTH-1:0]    exp_rdata;
  logic                          port_chk;
  logic [`IMX_CAMERA_COUNT-1:0]  exp_master;
  logic                          exp_trigger;
  logic                          exp_xclear_n;
  logic                          trig_chk;
  logic [31:0]                   exp_trig_width;
  logic [31:0]                   exp_trig_period;
  logic                          no_trig_chk;
  logic                          clear_chk;
  logic [31:0]                   exp_clear_width;
  logic                          final_chk;

  logic [31:0] stim [0:MAX_CMDS*5-1];
  int          timeouts;
  int          bad_cmds;
  bit          timed_out;

  always #50 clk = ~clk;

  axi_imx_control i_axi_imx_control (
    .clk               (clk),
    .w_axi_rst         (w_axi_rst),
    .i_awvalid         (awvalid),
    .i_awaddr          (awaddr),
    .o_awready         (o_awready),
    .i_wvalid          (wvalid),
    .i_wdata           (wdata),
    .o_wready          (o_wready),
    .o_bvalid          (o_bvalid),
    .i_bready          (bready),
    .o_bresp           (o_bresp),
    .i_arvalid         (arvalid),
    .i_araddr          (araddr),
    .o_arready         (o_arready),
    .o_rvalid          (o_rvalid),
    .i_rready          (rready),
    .o_rresp           (o_rresp),
    .o_rdata           (o_rdata),
    .o_imx_trigger     (o_imx_trigger),
    .o_cam_xclear_n    (o_cam_xclear_n),
    .o_cam_master_mode (o_cam_master_mode)
  );

  imx_ctrl_checker response_checker (
    .clk                (clk),
    .w_axi_rst          (w_axi_rst),
    .i_bvalid           (o_bvalid),
    .i_bready           (bready),
    .i_bresp            (o_bresp),
    .i_rvalid           (o_rvalid),
    .i_rready           (rready),
    .i_rresp            (o_rresp),
    .i_rdata            (o_rdata),
    .i_imx_trigger      (o_imx_trigger),
    .i_cam_xclear_n     (o_cam_xclear_n),
    .i_cam_master_mode  (o_cam_master_mode),
    .i_exp_resp         (exp_resp),
    .i_exp_rdata        (exp_rdata),
    .i_port_chk         (port_chk),
    .i_exp_master       (exp_master),
    .i_exp_trigger      (exp_trigger),
    .i_exp_xclear_n     (exp_xclear_n),
    .i_trig_chk         (trig_chk),
    .i_exp_trig_width   (exp_trig_width),
    .i_exp_trig_period  (exp_trig_period),
    .i_no_trig_chk      (no_trig_chk),
    .i_clear_chk        (clear_chk),
    .i_exp_clear_width  (exp_clear_width),
    .i_final_chk        (final_chk)
  );

  task note_timeout(input string what);
    timeouts++;
    timed_out = 1'b1;
    $display("Timeout at %0t: no %s within %0d cycles", $time, what, TIMEOUT);
  endtask

  task axi_write(input logic [7:0] addr, input logic [31:0] data, input logic [1:0] resp,
                 input logic bp);
    int n;
    @(negedge clk);
    awaddr   = addr;
    wdata    = data;
    awvalid  = 1'b1;
    wvalid   = 1'b1;
    bready   = !bp;
    exp_resp = resp;
    n = 0;
    // Address and data are taken on the same edge
    do begin
      @(posedge clk);
      n++;
    end while (!(o_awready && o_wready) && n < TIMEOUT);
    if (!(o_awready && o_wready)) note_timeout("write address and data handshake");
    @(negedge clk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    if (timed_out) return;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!o_bvalid && n < TIMEOUT);
    if (!o_bvalid) begin
      note_timeout("write response");
      return;
    end
    // Hold off the response for a few cycles, then take it
    if (bp) begin
      repeat (3) @(negedge clk);
      bready = 1'b1;
      @(posedge clk);
    end
    @(negedge clk);
    bready = 1'b0;
  endtask

  task axi_read(input logic [7:0] addr, input logic [1:0] resp, input logic [31:0] rdata,
                input logic bp);
    int n;
    @(negedge clk);
    araddr    = addr;
    arvalid   = 1'b1;
    rready    = !bp;
    exp_resp  = resp;
    exp_rdata = rdata;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!o_arready && n < TIMEOUT);
    if (!o_arready) note_timeout("read address handshake");
    @(negedge clk);
    arvalid = 1'b0;
    if (timed_out) return;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!o_rvalid && n < TIMEOUT);
    if (!o_rvalid) begin
      note_timeout("read response");
      return;
    end
    if (bp) begin
      repeat (3) @(negedge clk);
      rready = 1'b1;
      @(posedge clk);
    end
    @(negedge clk);
    rready = 1'b0;
  endtask

  task check_ports(input logic [31:0] master, input logic [31:0] levels);
    @(negedge clk);
    exp_master   = master[`IMX_CAMERA_COUNT-1:0];
    exp_trigger  = levels[0];
    exp_xclear_n = levels[1];
    port_chk     = 1'b1;
    @(negedge clk);
    port_chk     = 1'b0;
  endtask

  initial begin
    int          idx;
    logic [31:0] op;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] resp;
    logic [31:0] rdata;
    clk = 1'b0;
    w_axi_rst = 1'b1;
    awvalid = 1'b0;
    awaddr = '0;
    wvalid = 1'b0;
    wdata = '0;
    bready = 1'b0;
    arvalid = 1'b0;
    araddr = '0;
    rready = 1'b0;
    exp_resp = '0;
    exp_rdata = '0;
    port_chk = 1'b0;
    exp_master = '0;
    exp_trigger = 1'b0;
    exp_xclear_n = 1'b1;
    trig_chk = 1'b0;
    exp_trig_width = '0;
    exp_trig_period = '0;
    no_trig_chk = 1'b0;
    clear_chk = 1'b0;
    exp_clear_width = '0;
    final_chk = 1'b0;
    timeouts = 0;
    bad_cmds = 0;
    timed_out = 1'b0;
    $readmemh("verification/imx_ctrl_stimulus.txt", stim);
    repeat (8) @(negedge clk);
    w_axi_rst = 1'b0;

    idx = 0;
    while (idx < MAX_CMDS && !timed_out && stim[idx*5] != 32'h0) begin
      op    = stim[idx*5];
      addr  = stim[idx*5+1];
      data  = stim[idx*5+2];
      resp  = stim[idx*5+3];
      rdata = stim[idx*5+4];
      case (op)
        32'h1, 32'h2: axi_write(addr[7:0], data, resp[1:0], op == 32'h2);
        32'h3, 32'h4: axi_read(addr[7:0], resp[1:0], rdata, op == 32'h4);
        32'h5: repeat (data) @(negedge clk);
        32'h6: check_ports(addr, data);
        32'h7: begin
          exp_trig_width  = addr;
          exp_trig_period = data;
          trig_chk        = 1'b1;
        end
        32'h8: trig_chk = 1'b0;
        32'h9: no_trig_chk = data[0];
        32'ha: begin
          exp_clear_width = data;
          clear_chk       = 1'b1;
        end
        32'hb: clear_chk = 1'b0;
        default: begin
          bad_cmds++;
          $display("Unknown command %0h on stimulus line %0d", op, idx);
        end
      endcase
      idx++;
    end

    @(negedge clk);
    final_chk = 1'b1;
    @(negedge clk);
    final_chk = 1'b0;
    $display("Errors: %0d failed checks, %0d timeouts, %0d bad stimulus lines",
             response_checker.error_count, timeouts, bad_cmds);
    if (timed_out || bad_cmds != 0 || response_checker.error_count != 0) begin
      $display("Test failed");
    end else begin
      $display("Test passed");
    end
    $finish;
  end

endmodule

// File: verification/imx_ctrl_stimulus.txt
// Columns: op addr data resp rdata, all hex. Ops: 1 write, 2 write with back-pressure, 3 read,
// 4 read with back-pressure, 5 wait, 6 ports, 7/8 trigger check on/off, 9 quiet, a/b clear, 0 end
6 00 2 0 0
3 08 0 0 64
3 0C 0 0 64
3 10 0 0 5A550
3 00 0 0 0
3 14 0 0 3
3 1C 0 0 10000000
1 08 8 0 0
3 08 0 0 8
2 0C 3 0 0
4 0C 0 0 3
1 10 9 0 0
4 10 0 0 9
1 04 DEAD 2 0
3 04 0 2 0
2 18 1234 2 0
3 18 0 2 0
1 50 55 2 0
4 50 0 2 0
3 08 0 0 8
a 00 8 0 0
1 00 501 0 0
3 00 0 0 501
5 00 14 0 0
b 00 0 0 0
6 05 2 0 0
7 03 9 0 0
1 00 4 0 0
5 00 3C 0 0
8 00 0 0 0
1 00 0 0 0
9 00 1 0 0
5 00 1E 0 0
9 00 0 0 0
6 00 2 0 0
3 00 0 0 0
0 00 0 0 0

// File: flist.f
+incdir+hw
hw/imx_ctrl_pkg.sv
hw/axi_lite_reg_slave.sv
hw/imx_ctrl_regs.sv
hw/imx_exposure_timing.sv
hw/axi_imx_control.sv
verification/imx_ctrl_checker.sv
verification/tb_axi_imx_control.sv

// File: run_sim.sh
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_axi_imx_control \
  -f flist.f

out=$(./obj_dir/Vtb_axi_imx_control)
echo "$out"

if grep -q "Test passed" <<< "$out"; then
  exit 0
else
  exit 1
fi
